// ==== bench/cache_tests.txt ====
# op addr sel wdata expect; read and rdhit check expect, rdhit also needs hit latency
# write ignores expect; idle takes the cycle count as addr and the least refresh rise as expect
read 00000100 0 00000000 ffbf0040
rdhit 0000010c 0 00000000 ffbc0043
rdhit 0000011c 0 00000000 ffb80047
rdhit ff800104 0 00000000 ffbe0041
write 00000108 5 11223344 00000000
rdhit 00000108 0 00000000 ff220044
write 00000108 a aabbccdd 00000000
rdhit 00000108 0 00000000 aa22cc44
read 0000090c 0 00000000 fdbc0243
read 00000108 0 00000000 aa22cc44
rdhit 00000100 0 00000000 ffbf0040
rdhit 0000011c 0 00000000 ffb80047
write 00400a10 f deadbeef 00000000
rdhit 00400a10 0 00000000 deadbeef
read 00000a10 0 00000000 fd7b0284
read 00400a10 0 00000000 deadbeef
rdhit 00400a14 0 00000000 fd7a0285
read 00000060 0 00000000 ffe70018
read 00001060 0 00000000 fbe70418
read 00000060 0 00000000 ffe70018
read 00201064 0 00000000 fbe60419
read 00001060 0 00000000 fbe70418
idle 000005dc 0 00000000 00000002
read 00400a10 0 00000000 deadbeef
read 00000108 0 00000000 aa22cc44
read 0000090c 0 00000000 fdbc0243

// ==== src.f ====
rtl/cache_pkg.sv
rtl/cache_wb_port.sv
rtl/line_store.sv
rtl/cache_ctrl.sv
rtl/sdrc_burst_engine.sv
rtl/sdram_cache_top.sv
bench/clk_gen.sv
bench/sdrc_model.sv
bench/tb_sdram_cache.sv

// ==== run.sh ====
#!/bin/sh
# build the cache testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_sdram_cache -o tb_sdram_cache
./obj_dir/tb_sdram_cache > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== bench/tb_sdram_cache.sv ====
// ======================================================================
// SDRAM cache testbench
// runs the Wishbone accesses of the test file against the cache and an
// SDRAM controller model, checks read data, hit latency and refreshes
// ======================================================================
`timescale 1ns/1ps

module tb_sdram_cache;

  localparam int ACK_TIMEOUT = 2000;
  localparam int RESET_TIMEOUT = 10;
  // falling edges from the drive edge to the one showing ack on a hit:
  // stb sampled on the first edge, ack high after the third one
  localparam int HIT_WAITS = 4;
  localparam string TEST_FILE = "bench/cache_tests.txt";

  logic clk;
  logic rst_n;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [3:0] wb_sel;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic wb_ack;
  cache_pkg::sdrc_cmd_t sdrc;
  logic sdram_power_down;
  logic sdram_selfrefresh;
  logic [3:0] sdrc_dqm;
  logic [31:0] sdrc_rdata;
  logic sdrc_init_done;
  logic sdrc_cmd_ack;
  logic [31:0] refresh_count;

  int pass_count;
  int fail_count;
  int test_num;
  logic aborted;

  clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  sdram_cache_top i_sdram_cache_top (
    .clk               (clk),
    .rst_n             (rst_n),
    .wb_cyc            (wb_cyc),
    .wb_stb            (wb_stb),
    .wb_we             (wb_we),
    .wb_sel            (wb_sel),
    .wb_adr            (wb_adr),
    .wb_dat_w          (wb_dat_w),
    .wb_dat_r          (wb_dat_r),
    .wb_ack            (wb_ack),
    .sdrc              (sdrc),
    .sdram_power_down  (sdram_power_down),
    .sdram_selfrefresh (sdram_selfrefresh),
    .sdrc_dqm          (sdrc_dqm),
    .sdrc_rdata        (sdrc_rdata),
    .sdrc_init_done    (sdrc_init_done),
    .sdrc_cmd_ack      (sdrc_cmd_ack)
  );

  sdrc_model i_sdrc_model (
    .clk            (clk),
    .rst_n          (rst_n),
    .sdrc           (sdrc),
    .sdrc_rdata     (sdrc_rdata),
    .sdrc_init_done (sdrc_init_done),
    .sdrc_cmd_ack   (sdrc_cmd_ack),
    .refresh_count  (refresh_count)
  );

  // one classic cycle, outputs sampled on falling edges
  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output int waits, output logic got_ack);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_sel <= sel;
    wb_adr <= adr;
    wb_dat_w <= wdata;
    got_ack = 1'b0;
    waits = 0;
    rdata = '0;
    while (!got_ack && waits < ACK_TIMEOUT) begin
      @(negedge clk);
      waits++;
      if (wb_ack) begin
        got_ack = 1'b1;
        rdata = wb_dat_r;
      end
    end
    // strobe drops on the edge after ack
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  // idle: arg is the cycle count, expect_val the least refresh rise
  task automatic run_entry(input string op_name, input logic [31:0] arg,
                           input logic [3:0] sel, input logic [31:0] wdata,
                           input logic [31:0] expect_val);
    logic [31:0] rdata;
    logic [31:0] ref_before;
    logic [31:0] ref_after;
    logic got_ack;
    int waits;
    int errors;
    errors = 0;
    test_num++;
    if (op_name == "idle") begin
      @(negedge clk);
      ref_before = refresh_count;
      repeat (arg) @(posedge clk);
      @(negedge clk);
      ref_after = refresh_count;
      if (ref_after - ref_before < expect_val) begin
        $display("FAILED test %0d refresh_count rise got %h expected at least %h",
                 test_num, ref_after - ref_before, expect_val);
        errors++;
      end
    end else if (op_name == "read" || op_name == "rdhit" || op_name == "write") begin
      wb_access(op_name == "write", arg, sel, wdata, rdata, waits, got_ack);
      if (!got_ack) begin
        $display("test %0d timed out waiting for wb_ack after %0d cycles", test_num, waits);
        errors++;
        aborted = 1'b1;
      end else begin
        if (op_name != "write" && rdata !== expect_val) begin
          $display("FAILED test %0d wb_dat_r got %h expected %h", test_num, rdata, expect_val);
          errors++;
        end
        if (op_name == "rdhit" && waits != HIT_WAITS) begin
          $display("FAILED test %0d wb_ack latency got %h expected %h",
                   test_num, waits, HIT_WAITS);
          errors++;
        end
      end
    end else begin
      $display("test %0d has an unknown operation %s", test_num, op_name);
      errors++;
    end
    // low-power controls and data mask stay inactive
    @(negedge clk);
    if (sdram_power_down !== 1'b0) begin
      $display("FAILED test %0d sdram_power_down got %h expected %h",
               test_num, sdram_power_down, 1'b0);
      errors++;
    end
    if (sdram_selfrefresh !== 1'b0) begin
      $display("FAILED test %0d sdram_selfrefresh got %h expected %h",
               test_num, sdram_selfrefresh, 1'b0);
      errors++;
    end
    if (sdrc_dqm !== 4'h0) begin
      $display("FAILED test %0d sdrc_dqm got %h expected %h", test_num, sdrc_dqm, 4'h0);
      errors++;
    end
    if (errors == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("test %0d %s %h %s", test_num, op_name, arg, (errors == 0) ? "passed" : "failed");
  endtask

  initial begin
    string text_line;
    string op_name;
    logic [31:0] arg;
    logic [3:0] sel;
    logic [31:0] wdata;
    logic [31:0] expect_val;
    int fd;
    int n;
    int fields;
    int reset_wait;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_sel = 4'h0;
    wb_adr = '0;
    wb_dat_w = '0;
    pass_count = 0;
    fail_count = 0;
    test_num = 0;
    aborted = 1'b0;
    reset_wait = 0;
    // unknown at time zero counts as still in reset
    while (rst_n !== 1'b1 && reset_wait < RESET_TIMEOUT) begin
      @(negedge clk);
      reset_wait++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset still asserted after %0d cycles", reset_wait);
      fail_count++;
      aborted = 1'b1;
    end
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", TEST_FILE);
      fail_count++;
    end else begin
      while (!$feof(fd) && !aborted) begin
        text_line = "";
        n = $fgets(text_line, fd);
        // blank lines and # comments carry no test
        if (n > 1 && text_line.substr(0, 0) != "#") begin
          fields = $sscanf(text_line, "%s %h %h %h %h", op_name, arg, sel, wdata, expect_val);
          if (fields != 5) begin
            $display("malformed test line: %s", text_line);
            fail_count++;
          end else begin
            run_entry(op_name, arg, sel, wdata, expect_val);
          end
        end
      end
      $fclose(fd);
    end
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/sdrc_model.sv ====
// ======================================================================
// SDRAM controller model
// acks every command two cycles after cmd_en, returns read bursts after
// the read wait and counts refresh commands
// ======================================================================
`timescale 1ns/1ps

module sdrc_model (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cache_pkg::sdrc_cmd_t sdrc,
  output logic [31:0]          sdrc_rdata,
  output logic                 sdrc_init_done,
  output logic                 sdrc_cmd_ack,
  output logic [31:0]          refresh_count
);

  // power-up delay before the controller reports ready
  localparam int INIT_CYCLES = 20;

  // only written words are stored, the rest read as the fill pattern
  logic [31:0] mem [logic [cache_pkg::SDRC_ADDR_BITS-1:0]];
  logic [1:0] ack_pipe;
  int init_cnt;
  logic wr_busy;
  int wr_beat;
  int wr_last;
  logic [cache_pkg::SDRC_ADDR_BITS-1:0] wr_addr;
  logic rd_busy;
  int rd_cnt;
  int rd_last;
  logic [cache_pkg::SDRC_ADDR_BITS-1:0] rd_addr;

  // address in the low half, its complement in the high half
  function automatic logic [31:0] read_word(input logic [cache_pkg::SDRC_ADDR_BITS-1:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {~addr[15:0], addr[15:0]};
  endfunction

  assign sdrc_cmd_ack = ack_pipe[1];

  always @(posedge clk) begin
    if (!rst_n) begin
      ack_pipe <= 2'b00;
      init_cnt <= 0;
      sdrc_init_done <= 1'b0;
      refresh_count <= '0;
      wr_busy <= 1'b0;
      rd_busy <= 1'b0;
      sdrc_rdata <= '0;
    end else begin
      // ack two cycles behind the command pulse
      ack_pipe <= {ack_pipe[0], sdrc.cmd_en};
      if (init_cnt < INIT_CYCLES) begin
        init_cnt <= init_cnt + 1;
      end else begin
        sdrc_init_done <= 1'b1;
      end
      if (sdrc.cmd_en) begin
        case (sdrc.cmd)
          cache_pkg::CMD_REFRESH: refresh_count <= refresh_count + 1;
          // first word comes with the command itself
          cache_pkg::CMD_WRITE: begin
            mem[sdrc.addr] = sdrc.wdata;
            wr_addr <= sdrc.addr;
            wr_beat <= 1;
            wr_last <= int'(sdrc.data_len);
            wr_busy <= 1'b1;
          end
          cache_pkg::CMD_READ: begin
            rd_addr <= sdrc.addr;
            rd_cnt <= 1;
            rd_last <= int'(sdrc.data_len);
            rd_busy <= 1'b1;
          end
          default: ;
        endcase
      end
      // remaining write beats on consecutive cycles
      if (wr_busy) begin
        mem[wr_addr + cache_pkg::SDRC_ADDR_BITS'(wr_beat)] = sdrc.wdata;
        wr_beat <= wr_beat + 1;
        if (wr_beat == wr_last) begin
          wr_busy <= 1'b0;
        end
      end
      // word 0 lands on the bus READ_WAITS cycles after the command
      if (rd_busy) begin
        rd_cnt <= rd_cnt + 1;
        if (rd_cnt >= cache_pkg::READ_WAITS - 1) begin
          sdrc_rdata <= read_word(rd_addr +
                        cache_pkg::SDRC_ADDR_BITS'(rd_cnt - (cache_pkg::READ_WAITS - 1)));
        end
        if (rd_cnt == cache_pkg::READ_WAITS - 1 + rd_last) begin
          rd_busy <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== bench/clk_gen.sv ====
// ======================================================================
// clock and reset generator
// 40 ns clock, reset held low over the first two rising edges
// ======================================================================
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 20;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // released on the second rising edge, seen high from the third
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== rtl/sdram_cache_top.sv ====
// ======================================================================
// SDRAM cache top level
// Wishbone port, controller, line store and burst engine in front of
// the SDRAM controller command port
// ======================================================================
`timescale 1ns/1ps

module sdram_cache_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [3:0]            wb_sel,
  input  logic [31:0]           wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack,
  output cache_pkg::sdrc_cmd_t  sdrc,
  output logic                  sdram_power_down,
  output logic                  sdram_selfrefresh,
  output logic [3:0]            sdrc_dqm,
  input  logic [31:0]           sdrc_rdata,
  input  logic                  sdrc_init_done,
  input  logic                  sdrc_cmd_ack
);

  // port to controller
  cache_pkg::cache_req_t req;
  logic req_valid;
  logic req_done;
  logic [31:0] rd_data;

  // controller to line store
  logic [cache_pkg::LINE_BITS-1:0] line;
  logic [cache_pkg::COL_COUNT-1:0][3:0] col_we;
  logic [31:0] col_wdata;
  logic tag_we;
  cache_pkg::line_tag_t tag_wdata;
  logic [cache_pkg::COL_COUNT-1:0][31:0] col_rdata;
  cache_pkg::line_tag_t tag_rdata;

  // controller to burst engine
  cache_pkg::burst_op_e op;
  logic [cache_pkg::SDRC_ADDR_BITS-1:0] op_addr;
  logic op_start;
  logic op_done;
  logic fill_we;
  logic [cache_pkg::COL_BITS-1:0] fill_col;
  logic [31:0] fill_data;
  logic init_done;

  cache_wb_port i_cache_wb_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_sel    (wb_sel),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .req       (req),
    .req_valid (req_valid),
    .req_done  (req_done),
    .rd_data   (rd_data)
  );

  cache_ctrl i_cache_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_done  (req_done),
    .rd_data   (rd_data),
    .line      (line),
    .col_we    (col_we),
    .col_wdata (col_wdata),
    .tag_we    (tag_we),
    .tag_wdata (tag_wdata),
    .col_rdata (col_rdata),
    .tag_rdata (tag_rdata),
    .op        (op),
    .op_addr   (op_addr),
    .op_start  (op_start),
    .op_done   (op_done),
    .fill_we   (fill_we),
    .fill_col  (fill_col),
    .fill_data (fill_data),
    .init_done (init_done)
  );

  line_store i_line_store (
    .clk       (clk),
    .line      (line),
    .col_we    (col_we),
    .col_wdata (col_wdata),
    .tag_we    (tag_we),
    .tag_wdata (tag_wdata),
    .col_rdata (col_rdata),
    .tag_rdata (tag_rdata)
  );

  sdrc_burst_engine i_sdrc_burst_engine (
    .clk               (clk),
    .rst_n             (rst_n),
    .op                (op),
    .op_addr           (op_addr),
    .op_start          (op_start),
    .op_done           (op_done),
    .col_rdata         (col_rdata),
    .fill_we           (fill_we),
    .fill_col          (fill_col),
    .fill_data         (fill_data),
    .sdrc              (sdrc),
    .sdram_power_down  (sdram_power_down),
    .sdram_selfrefresh (sdram_selfrefresh),
    .sdrc_dqm          (sdrc_dqm),
    .sdrc_rdata        (sdrc_rdata),
    .sdrc_cmd_ack      (sdrc_cmd_ack),
    .sdrc_init_done    (sdrc_init_done),
    .init_done         (init_done)
  );

endmodule

// ==== rtl/sdrc_burst_engine.sv ====
// ======================================================================
// SDRAM controller burst engine
// runs refresh, line evict (activate + 8-word write) and line fill
// (activate + 8-word read) on the controller command port
// ======================================================================
`timescale 1ns/1ps

module sdrc_burst_engine (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  cache_pkg::burst_op_e                       op,
  input  logic [cache_pkg::SDRC_ADDR_BITS-1:0]       op_addr,
  input  logic                                       op_start,
  output logic                                       op_done,
  input  logic [cache_pkg::COL_COUNT-1:0][31:0]      col_rdata,
  output logic                                       fill_we,
  output logic [cache_pkg::COL_BITS-1:0]             fill_col,
  output logic [31:0]                                fill_data,
  output cache_pkg::sdrc_cmd_t                       sdrc,
  output logic                                       sdram_power_down,
  output logic                                       sdram_selfrefresh,
  output logic [3:0]                                 sdrc_dqm,
  input  logic [31:0]                                sdrc_rdata,
  input  logic                                       sdrc_cmd_ack,
  input  logic                                       sdrc_init_done,
  output logic                                       init_done
);

  typedef enum logic [3:0] {
    E_WAIT_INIT,
    E_INIT_ACK,
    E_IDLE,
    E_REF_ACK,
    E_ACT_ACK,
    E_WR_BEATS,
    E_WR_ACK,
    E_RD_BEATS,
    E_RD_END
  } eng_state_e;

  eng_state_e state;
  cache_pkg::burst_op_e cur_op;
  logic [cache_pkg::COL_BITS-1:0] beat;
  logic [cache_pkg::RD_CNT_BITS-1:0] rd_cnt;
  // write ack may arrive while beats are still going out
  logic ack_seen;

  // whole words only, no low-power modes
  assign sdram_power_down = 1'b0;
  assign sdram_selfrefresh = 1'b0;
  assign sdrc_dqm = 4'b0000;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= E_WAIT_INIT;
      sdrc.cmd_en <= 1'b0;
      op_done <= 1'b0;
      fill_we <= 1'b0;
      init_done <= 1'b0;
      ack_seen <= 1'b0;
    end else begin
      // commands are single-cycle pulses
      sdrc.cmd_en <= 1'b0;
      op_done <= 1'b0;
      fill_we <= 1'b0;
      case (state)
        // one refresh serves as the init step
        E_WAIT_INIT: begin
          if (sdrc_init_done) begin
            sdrc.cmd_en <= 1'b1;
            sdrc.cmd <= cache_pkg::CMD_REFRESH;
            state <= E_INIT_ACK;
          end
        end
        E_INIT_ACK: begin
          if (sdrc_cmd_ack) begin
            init_done <= 1'b1;
            state <= E_IDLE;
          end
        end
        E_IDLE: begin
          if (op_start) begin
            cur_op <= op;
            if (op == cache_pkg::OP_REFRESH) begin
              sdrc.cmd_en <= 1'b1;
              sdrc.cmd <= cache_pkg::CMD_REFRESH;
              state <= E_REF_ACK;
            end else if (op != cache_pkg::OP_NONE) begin
              // open bank and row of the line first
              sdrc.cmd_en <= 1'b1;
              sdrc.cmd <= cache_pkg::CMD_ACTIVATE;
              sdrc.addr <= op_addr;
              state <= E_ACT_ACK;
            end
          end
        end
        E_REF_ACK: begin
          if (sdrc_cmd_ack) begin
            op_done <= 1'b1;
            state <= E_IDLE;
          end
        end
        E_ACT_ACK: begin
          if (sdrc_cmd_ack) begin
            sdrc.cmd_en <= 1'b1;
            sdrc.addr <= op_addr;
            sdrc.data_len <= 8'(cache_pkg::COL_COUNT - 1);
            if (cur_op == cache_pkg::OP_EVICT) begin
              // column 0 rides with the write command
              sdrc.cmd <= cache_pkg::CMD_WRITE;
              sdrc.wdata <= col_rdata[0];
              beat <= 3'd1;
              ack_seen <= 1'b0;
              state <= E_WR_BEATS;
            end else begin
              sdrc.cmd <= cache_pkg::CMD_READ;
              rd_cnt <= '0;
              state <= E_RD_BEATS;
            end
          end
        end
        // columns 1..7 on the following cycles
        E_WR_BEATS: begin
          sdrc.wdata <= col_rdata[beat];
          beat <= beat + 1'b1;
          if (sdrc_cmd_ack) begin
            ack_seen <= 1'b1;
          end
          if (beat == cache_pkg::COL_BITS'(cache_pkg::COL_COUNT - 1)) begin
            state <= E_WR_ACK;
          end
        end
        E_WR_ACK: begin
          if (ack_seen || sdrc_cmd_ack) begin
            op_done <= 1'b1;
            state <= E_IDLE;
          end
        end
        // rd_cnt counts from the read command cycle
        E_RD_BEATS: begin
          rd_cnt <= rd_cnt + 1'b1;
          if (rd_cnt >= cache_pkg::RD_CNT_BITS'(cache_pkg::READ_WAITS)) begin
            fill_we <= 1'b1;
            fill_col <= cache_pkg::COL_BITS'(rd_cnt -
                        cache_pkg::RD_CNT_BITS'(cache_pkg::READ_WAITS));
            fill_data <= sdrc_rdata;
          end
          if (rd_cnt == cache_pkg::RD_CNT_BITS'(cache_pkg::READ_WAITS +
                                                cache_pkg::COL_COUNT - 1)) begin
            state <= E_RD_END;
          end
        end
        // last column is written this cycle, done follows it
        E_RD_END: begin
          op_done <= 1'b1;
          state <= E_IDLE;
        end
        default: state <= E_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/cache_ctrl.sv ====
// ======================================================================
// cache controller
// hit check, byte-masked write hits, miss sequencing through evict and
// fill, tag clearing after reset and the auto-refresh timer
// ======================================================================
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  cache_pkg::cache_req_t                      req,
  input  logic                                       req_valid,
  output logic                                       req_done,
  output logic [31:0]                                rd_data,
  output logic [cache_pkg::LINE_BITS-1:0]            line,
  output logic [cache_pkg::COL_COUNT-1:0][3:0]       col_we,
  output logic [31:0]                                col_wdata,
  output logic                                       tag_we,
  output cache_pkg::line_tag_t                       tag_wdata,
  input  logic [cache_pkg::COL_COUNT-1:0][31:0]      col_rdata,
  input  cache_pkg::line_tag_t                       tag_rdata,
  output cache_pkg::burst_op_e                       op,
  output logic [cache_pkg::SDRC_ADDR_BITS-1:0]       op_addr,
  output logic                                       op_start,
  input  logic                                       op_done,
  input  logic                                       fill_we,
  input  logic [cache_pkg::COL_BITS-1:0]             fill_col,
  input  logic [31:0]                                fill_data,
  input  logic                                       init_done
);

  typedef enum logic [2:0] {
    S_CLEAR,
    S_WAIT_INIT,
    S_IDLE,
    S_LOOKUP,
    S_REFRESH,
    S_EVICT,
    S_FILL,
    S_REREAD
  } ctrl_state_e;

  ctrl_state_e state;
  logic [cache_pkg::LINE_BITS-1:0] clr_line;
  logic [cache_pkg::REFRESH_BITS-1:0] refresh_cnt;
  logic hit;

  // tag compare against the entry read for the request line
  assign hit = tag_rdata.valid && (tag_rdata.tag == req.addr.f.tag);
  assign req_done = (state == S_LOOKUP) && hit;
  assign rd_data = col_rdata[req.addr.f.col];

  // line store port, shared by clearing, hits and fill beats
  always_comb begin
    line = (state == S_CLEAR) ? clr_line : req.addr.f.line;
    col_we = '0;
    col_wdata = req.wdata;
    tag_we = 1'b0;
    tag_wdata = '0;
    case (state)
      // zero tag means invalid
      S_CLEAR: tag_we = 1'b1;
      S_LOOKUP: begin
        if (hit && req.we) begin
          col_we[req.addr.f.col] = req.sel;
          tag_we = 1'b1;
          tag_wdata = '{dirty: 1'b1, valid: 1'b1, tag: req.addr.f.tag};
        end
      end
      S_FILL: begin
        col_wdata = fill_data;
        if (fill_we) begin
          col_we[fill_col] = 4'hf;
        end
        // last column is already written when op_done arrives
        if (op_done) begin
          tag_we = 1'b1;
          tag_wdata = '{dirty: 1'b0, valid: 1'b1, tag: req.addr.f.tag};
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_CLEAR;
      clr_line <= '0;
      refresh_cnt <= '0;
      op <= cache_pkg::OP_NONE;
      op_addr <= '0;
      op_start <= 1'b0;
    end else begin
      op_start <= 1'b0;
      case (state)
        // walk every line, the engine runs its init refresh meanwhile
        S_CLEAR: begin
          clr_line <= clr_line + 1'b1;
          if (clr_line == cache_pkg::LINE_BITS'(cache_pkg::LINE_COUNT - 1)) begin
            state <= S_WAIT_INIT;
          end
        end
        S_WAIT_INIT: begin
          if (init_done) begin
            refresh_cnt <= '0;
            state <= S_IDLE;
          end
        end
        S_IDLE: begin
          refresh_cnt <= refresh_cnt + 1'b1;
          // refresh only between requests
          if (refresh_cnt > cache_pkg::REFRESH_BITS'(cache_pkg::REFRESH_PERIOD)) begin
            op <= cache_pkg::OP_REFRESH;
            op_start <= 1'b1;
            state <= S_REFRESH;
          end else if (req_valid) begin
            state <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          if (hit) begin
            state <= S_IDLE;
          end else if (tag_rdata.dirty) begin
            // victim goes back to where its own tag points
            op <= cache_pkg::OP_EVICT;
            op_addr <= {tag_rdata.tag, req.addr.f.line, {cache_pkg::COL_BITS{1'b0}}};
            op_start <= 1'b1;
            state <= S_EVICT;
          end else begin
            op <= cache_pkg::OP_FILL;
            op_addr <= {req.addr.f.tag, req.addr.f.line, {cache_pkg::COL_BITS{1'b0}}};
            op_start <= 1'b1;
            state <= S_FILL;
          end
        end
        S_REFRESH: begin
          if (op_done) begin
            refresh_cnt <= '0;
            state <= S_IDLE;
          end
        end
        S_EVICT: begin
          if (op_done) begin
            op <= cache_pkg::OP_FILL;
            op_addr <= {req.addr.f.tag, req.addr.f.line, {cache_pkg::COL_BITS{1'b0}}};
            op_start <= 1'b1;
            state <= S_FILL;
          end
        end
        S_FILL: begin
          if (op_done) begin
            state <= S_REREAD;
          end
        end
        // one read cycle so the new tag and words show on the outputs
        S_REREAD: state <= S_LOOKUP;
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/line_store.sv ====
// ======================================================================
// cache line store
// tag memory plus eight byte-enabled column memories, all read one
// cycle after the line index is presented
// ======================================================================
`timescale 1ns/1ps

module line_store (
  input  logic                                       clk,
  input  logic [cache_pkg::LINE_BITS-1:0]            line,
  input  logic [cache_pkg::COL_COUNT-1:0][3:0]       col_we,
  input  logic [31:0]                                col_wdata,
  input  logic                                       tag_we,
  input  cache_pkg::line_tag_t                       tag_wdata,
  output logic [cache_pkg::COL_COUNT-1:0][31:0]      col_rdata,
  output cache_pkg::line_tag_t                       tag_rdata
);

  // dirty, valid and tag per line
  cache_pkg::line_tag_t tag_mem [cache_pkg::LINE_COUNT];

  // read returns the old entry when written in the same cycle
  always_ff @(posedge clk) begin
    if (tag_we) begin
      tag_mem[line] <= tag_wdata;
    end
    tag_rdata <= tag_mem[line];
  end

  // one memory per column so a whole line reads in one cycle
  for (genvar c = 0; c < cache_pkg::COL_COUNT; c++) begin : g_col
    logic [3:0][7:0] col_mem [cache_pkg::LINE_COUNT];

    always_ff @(posedge clk) begin
      // per-byte enables carry the Wishbone select on write hits
      for (int b = 0; b < 4; b++) begin
        if (col_we[c][b]) begin
          col_mem[line][b] <= col_wdata[8*b +: 8];
        end
      end
      col_rdata[c] <= col_mem[line];
    end
  end

endmodule

// ==== rtl/cache_wb_port.sv ====
// ======================================================================
// Wishbone classic slave port
// latches one request, hands it to the cache controller and answers
// with registered read data and a single-cycle ack
// ======================================================================
`timescale 1ns/1ps

module cache_wb_port (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [3:0]            wb_sel,
  input  logic [31:0]           wb_adr,
  input  logic [31:0]           wb_dat_w,
  output logic [31:0]           wb_dat_r,
  output logic                  wb_ack,
  output cache_pkg::cache_req_t req,
  output logic                  req_valid,
  input  logic                  req_done,
  input  logic [31:0]           rd_data
);

  // set from accept until the ack has been seen by the master
  logic busy;
  logic accept;

  // strobe is still high during the ack cycle, busy masks it
  assign accept = wb_cyc && wb_stb && !busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      req_valid <= 1'b0;
      wb_ack <= 1'b0;
    end else begin
      // one ack per completed request
      wb_ack <= req_done;
      if (req_done) begin
        req_valid <= 1'b0;
      end
      if (wb_ack) begin
        busy <= 1'b0;
      end else if (accept) begin
        busy <= 1'b1;
        req_valid <= 1'b1;
      end
    end
  end

  // request payload and returned word
  always_ff @(posedge clk) begin
    if (accept) begin
      req.addr.raw <= wb_adr;
      req.we <= wb_we;
      req.sel <= wb_sel;
      req.wdata <= wb_dat_w;
    end
    if (req_done) begin
      wb_dat_r <= rd_data;
    end
  end

endmodule

// ==== rtl/cache_pkg.sv ====
// ======================================================================
// cache package
// geometry, SDRAM controller command codes and the shared types of the
// direct-mapped write-back SDRAM cache
// ======================================================================
package cache_pkg;

  // 8 words per line, 64 lines, 2 KB in all
  localparam int COL_BITS = 3;
  localparam int LINE_BITS = 6;
  localparam int TAG_BITS = 12;
  localparam int COL_COUNT = 8;
  localparam int LINE_COUNT = 64;

  // 2M words of 32 bits behind the controller
  localparam int SDRC_ADDR_BITS = 21;
  // cycles from the read command to the first data word
  localparam int READ_WAITS = 4;
  // idle cycles between two auto-refresh commands
  localparam int REFRESH_PERIOD = 600;

  // counter widths derived from the above
  localparam int REFRESH_BITS = $clog2(REFRESH_PERIOD + 2);
  localparam int RD_CNT_BITS = $clog2(READ_WAITS + COL_COUNT);

  // controller command codes
  localparam logic [2:0] CMD_REFRESH = 3'b001;
  localparam logic [2:0] CMD_ACTIVATE = 3'b011;
  localparam logic [2:0] CMD_WRITE = 3'b100;
  localparam logic [2:0] CMD_READ = 3'b101;

  // byte address split, bits 31..23 lie outside the SDRAM
  typedef struct packed {
    logic [8:0] unused;
    logic [TAG_BITS-1:0] tag;
    logic [LINE_BITS-1:0] line;
    logic [COL_BITS-1:0] col;
    logic [1:0] byte_off;
  } cpu_addr_fields_t;

  typedef union packed {
    logic [31:0] raw;
    cpu_addr_fields_t f;
  } cpu_addr_u;

  // one Wishbone access as held by the port
  typedef struct packed {
    cpu_addr_u addr;
    logic we;
    logic [3:0] sel;
    logic [31:0] wdata;
  } cache_req_t;

  // per-line bookkeeping, 14 bits
  typedef struct packed {
    logic dirty;
    logic valid;
    logic [TAG_BITS-1:0] tag;
  } line_tag_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_REFRESH,
    OP_EVICT,
    OP_FILL
  } burst_op_e;

  // command bundle toward the SDRAM controller
  typedef struct packed {
    logic cmd_en;
    logic [2:0] cmd;
    logic [SDRC_ADDR_BITS-1:0] addr;
    logic [31:0] wdata;
    logic [7:0] data_len;
  } sdrc_cmd_t;

endpackage
